//--- list.f
+incdir+include
verilog/cpu_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/cpu_ifs.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/reg_file_sb.sv
verilog/execute_unit.sv
verilog/data_mem.sv
verilog/cpu_top.sv
bench/tb_cpu.sv

//--- include/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// each word is {opcode, rd, rs0, rs1 or imm4}
localparam int PROG_LEN = 42;

localparam logic [15:0] PROG [PROG_LEN] = '{
    // ldi r1 to r3 and a nop, then add sub and or xor shl addi
    16'h7135, 16'h720c, 16'h73f0, 16'h0000,
    16'h1412, 16'h2512, 16'h3613, 16'h4723, 16'h5813, 16'h6912, 16'h8a1d,
    // dependent chain with no nops in between
    16'h7107, 16'h8115, 16'h1211, 16'h6321, 16'h5432, 16'h2543,
    // stores to 0x42 and 0x3f from base r6 and reloads
    16'h7640, 16'ha462, 16'ha56f, 16'h9762, 16'h986f,
    16'h8881, 16'ha862, 16'h9962, 16'h9a6f,
    // taken beq over 28 and 29, untaken beq, jmp over 33 and 34
    16'h7b18, 16'hbba3, 16'h7cee, 16'h7dee, 16'hbb92, 16'h7c5a,
    16'hc023, 16'h7dbb, 16'h7ebb, 16'h8dcf,
    // countdown loop on r14 then jump to self
    16'h7f00, 16'h7e03, 16'h8eef, 16'hbef2, 16'hc026, 16'hc029
};

// test name for a program address
function automatic string section_of(input logic [7:0] pc);
    if (pc < 11) return "alu";
    if (pc < 17) return "dep";
    if (pc < 26) return "mem";
    return "branch";
endfunction

`endif

//--- bench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

    `include "tb_program.svh"

    localparam int MAX_WB = 64;

    logic                           clk;
    logic                           rst_n_i;
    logic                           stall_i;
    logic [cpu_isa_pkg::INST_W-1:0] inst_i;
    logic [7:0]                     inst_addr_o;
    logic                           wb_valid_o;
    logic [cpu_isa_pkg::REG_AW-1:0] wb_reg_o;
    logic [cpu_isa_pkg::DATA_W-1:0] wb_data_o;

    // expected write-backs in program order
    logic [3:0]  exp_reg [MAX_WB];
    logic [15:0] exp_data [MAX_WB];
    logic [7:0]  exp_pc [MAX_WB];
    int          exp_n;
    int          wb_idx;
    int          cycles;
    int          limit;
    int          value_errs;
    int          proto_errs;
    logic        stall_en;
    logic [31:0] lfsr;
    string       pass_name;

    cpu_top dut0 (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall_i),
        .inst_i(inst_i), .inst_addr_o(inst_addr_o),
        .wb_valid_o(wb_valid_o), .wb_reg_o(wb_reg_o), .wb_data_o(wb_data_o)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b = lfsr[0];
    endtask

    function automatic logic [15:0] imem_word(input logic [7:0] addr);
        if (addr < PROG_LEN) return PROG[addr];
        // past the program every word jumps to itself
        return {cpu_isa_pkg::OP_JMP, 4'h0, addr};
    endfunction

    function automatic string test_name(input int idx);
        if (idx >= exp_n) return {pass_name, "/extra"};
        return {pass_name, "/", section_of(exp_pc[idx])};
    endfunction

    // reference ISA model, records every register write
    task automatic run_model();
        logic [15:0] r [16];
        logic [15:0] m [256];
        logic [15:0] w;
        logic [15:0] res;
        logic [15:0] imm_s;
        logic [15:0] ea;
        logic [7:0]  pc;
        logic [7:0]  nxt;
        logic [3:0]  op;
        logic        wr;
        int          steps;
        for (int i = 0; i < 16; i++) r[i] = '0;
        pc = '0;
        exp_n = 0;
        for (steps = 0; steps < 1000; steps++) begin
            w = imem_word(pc);
            op = w[15:12];
            imm_s = {{12{w[3]}}, w[3:0]};
            ea = r[w[7:4]] + imm_s;
            nxt = pc + 8'd1;
            wr = 1'b1;
            res = '0;
            case (op)
                cpu_isa_pkg::OP_ADD:  res = r[w[7:4]] + r[w[3:0]];
                cpu_isa_pkg::OP_SUB:  res = r[w[7:4]] - r[w[3:0]];
                cpu_isa_pkg::OP_AND:  res = r[w[7:4]] & r[w[3:0]];
                cpu_isa_pkg::OP_OR:   res = r[w[7:4]] | r[w[3:0]];
                cpu_isa_pkg::OP_XOR:  res = r[w[7:4]] ^ r[w[3:0]];
                cpu_isa_pkg::OP_SHL:  res = r[w[7:4]] << r[w[3:0]][3:0];
                cpu_isa_pkg::OP_LDI:  res = {8'h00, w[7:0]};
                cpu_isa_pkg::OP_ADDI: res = ea;
                cpu_isa_pkg::OP_LD:   res = m[ea[7:0]];
                cpu_isa_pkg::OP_ST: begin
                    m[ea[7:0]] = r[w[11:8]];
                    wr = 1'b0;
                end
                cpu_isa_pkg::OP_BEQ: begin
                    wr = 1'b0;
                    if (r[w[11:8]] == r[w[7:4]]) nxt = pc + imm_s[7:0];
                end
                cpu_isa_pkg::OP_JMP: begin
                    wr = 1'b0;
                    nxt = w[7:0];
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                r[w[11:8]] = res;
                exp_reg[exp_n] = w[11:8];
                exp_data[exp_n] = res;
                exp_pc[exp_n] = pc;
                exp_n++;
            end
            if (op == cpu_isa_pkg::OP_JMP && nxt == pc) break;
            pc = nxt;
        end
    endtask

    task automatic run_pass(input string name, input logic with_stall);
        @(negedge clk);
        pass_name = name;
        rst_n_i <= 1'b0;
        stall_en <= with_stall;
        repeat (10) @(negedge clk);
        rst_n_i <= 1'b1;
        while (wb_idx < exp_n) @(posedge clk);
        // idle tail so stray write-backs still get caught
        repeat (20) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(negedge clk) begin : drive_inputs
        logic b0;
        logic b1;
        inst_i <= imem_word(inst_addr_o);
        if (rst_n_i && stall_en) begin
            random_bit(b0);
            random_bit(b1);
            stall_i <= b0 & b1;
        end else begin
            stall_i <= 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            wb_idx <= 0;
        end else if (wb_valid_o) begin
            wb_idx <= wb_idx + 1;
        end
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            cycles <= 0;
        end else if (cycles >= limit && wb_idx < exp_n) begin
            $display("timeout in %s: %0d of %0d write-backs seen", pass_name, wb_idx, exp_n);
            $display("=== FAIL ===");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    a_wb_match: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o && wb_idx < exp_n |->
            wb_reg_o == exp_reg[wb_idx] && wb_data_o == exp_data[wb_idx])
        else begin
            value_errs++;
            $display("ERR %s: expected r%0d=%h, actual r%0d=%h",
                     test_name($sampled(wb_idx)),
                     exp_reg[$sampled(wb_idx)], exp_data[$sampled(wb_idx)],
                     $sampled(wb_reg_o), $sampled(wb_data_o));
        end

    a_wb_count: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o |-> wb_idx < exp_n)
        else begin
            proto_errs++;
            $display("write-back beyond the %0d expected ones in %s", exp_n, pass_name);
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !wb_valid_o && inst_addr_o == '0)
        else begin
            proto_errs++;
            $display("reset left wb_valid_o high or inst_addr_o nonzero");
        end

    // fetch, decode, execute before the first retire
    a_start_quiet: assert property (@(posedge clk)
        $rose(rst_n_i) |-> !wb_valid_o [*3])
        else begin
            proto_errs++;
            $display("write-back too soon after reset release");
        end

    a_stall_no_wb: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> !wb_valid_o)
        else begin
            proto_errs++;
            $display("write-back right after a stalled cycle in %s", pass_name);
        end

    initial begin
        rst_n_i = 1'b0;
        stall_i = 1'b0;
        inst_i = '0;
        stall_en = 1'b0;
        lfsr = 32'hdf5e62d2;
        value_errs = 0;
        proto_errs = 0;
        pass_name = "reset";
        run_model();
        limit = exp_n * 12 + 200;
        run_pass("steady", 1'b0);
        run_pass("stalls", 1'b1);
        $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
    parameter int PC_W    = 8,
    parameter int DMEM_AW = 8
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           stall_i,
    input  logic [cpu_isa_pkg::INST_W-1:0] inst_i,
    output logic [PC_W-1:0]                inst_addr_o,
    output logic                           wb_valid_o,
    output logic [cpu_isa_pkg::REG_AW-1:0] wb_reg_o,
    output logic [cpu_isa_pkg::DATA_W-1:0] wb_data_o
);

    // redirect from execute
    logic                           branch;
    logic [PC_W-1:0]                branch_addr;

    // fetch to decode
    logic                           v_fd;
    logic                           stall_df;
    logic [cpu_isa_pkg::INST_W-1:0] inst_fd;
    logic [PC_W-1:0]                pc_fd;

    // decode to execute
    logic                           v_de;
    logic                           stall_ed;
    logic [PC_W-1:0]                pc_de;
    logic [cpu_isa_pkg::DATA_W-1:0] opr0_de;
    logic [cpu_isa_pkg::DATA_W-1:0] opr1_de;
    logic [cpu_isa_pkg::DATA_W-1:0] imm_de;
    logic [cpu_isa_pkg::REG_AW-1:0] wb_r_de;
    pipe_pkg::d_info_t              d_info_de;

    regfile_if                      rf_bus ();
    dmem_if #(.DMEM_AW(DMEM_AW))    dm_bus ();

    fetch_unit #(.PC_W(PC_W)) fetch (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(stall_df),
        .branch_i(branch), .branch_addr_i(branch_addr),
        .inst_i(inst_i), .inst_addr_o(inst_addr_o),
        .v_o(v_fd), .inst_o(inst_fd), .pc_o(pc_fd)
    );

    decode_unit #(.PC_W(PC_W)) decode (
        .clk(clk), .rst_n_i(rst_n_i),
        .v_i(v_fd), .inst_i(inst_fd), .pc_i(pc_fd),
        .stall_i(stall_ed), .branch_i(branch), .stall_o(stall_df),
        .rf(rf_bus.decode),
        .v_o(v_de), .pc_o(pc_de),
        .opr0_o(opr0_de), .opr1_o(opr1_de), .imm_o(imm_de),
        .wb_r_o(wb_r_de), .d_info_o(d_info_de)
    );

    reg_file_sb regs (
        .clk(clk), .rst_n_i(rst_n_i),
        .rf(rf_bus.regs),
        .wb_i(wb_valid_o), .wb_r_i(wb_reg_o), .result_i(wb_data_o)
    );

    // execute v_o is a retire marker, unused at this level
    execute_unit #(.PC_W(PC_W), .DMEM_AW(DMEM_AW)) exec (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(stall_i), .v_i(v_de), .pc_i(pc_de),
        .opr0_i(opr0_de), .opr1_i(opr1_de), .imm_i(imm_de),
        .wb_r_i(wb_r_de), .d_info_i(d_info_de),
        .stall_o(stall_ed), .v_o(),
        .dm(dm_bus.master),
        .wb_o(wb_valid_o), .wb_r_o(wb_reg_o), .result_o(wb_data_o),
        .branch_o(branch), .branch_addr_o(branch_addr)
    );

    data_mem #(.DMEM_AW(DMEM_AW)) dmem (
        .clk(clk),
        .dm(dm_bus.memory)
    );

endmodule

`default_nettype wire

//--- verilog/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int DMEM_AW = 8
) (
    input logic    clk,
    dmem_if.memory dm
);

    localparam int DEPTH = 1 << DMEM_AW;

    logic [cpu_isa_pkg::DATA_W-1:0] mem [DEPTH];

    // read data shows a same-cycle write one cycle later
    always_ff @(posedge clk) begin
        if (dm.we) begin
            mem[dm.addr] <= dm.wdata;
        end
        dm.rdata <= mem[dm.addr];
    end

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit #(
    parameter int PC_W    = 8,
    parameter int DMEM_AW = 8
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           stall_i,
    input  logic                           v_i,
    input  logic [PC_W-1:0]                pc_i,
    input  logic [cpu_isa_pkg::DATA_W-1:0] opr0_i,
    input  logic [cpu_isa_pkg::DATA_W-1:0] opr1_i,
    input  logic [cpu_isa_pkg::DATA_W-1:0] imm_i,
    input  logic [cpu_isa_pkg::REG_AW-1:0] wb_r_i,
    input  pipe_pkg::d_info_t              d_info_i,
    output logic                           stall_o,
    output logic                           v_o,
    dmem_if.master                         dm,
    output logic                           wb_o,
    output logic [cpu_isa_pkg::REG_AW-1:0] wb_r_o,
    output logic [cpu_isa_pkg::DATA_W-1:0] result_o,
    output logic                           branch_o,
    output logic [PC_W-1:0]                branch_addr_o
);

    logic [cpu_isa_pkg::DATA_W-1:0] opb;
    logic [cpu_isa_pkg::DATA_W-1:0] alu_out;
    logic [cpu_isa_pkg::DATA_W-1:0] wb_data;
    logic                           ld_phase;
    logic                           go;
    logic                           done;

    assign opb = d_info_i.use_imm ? imm_i : opr1_i;

    always_comb begin
        case (d_info_i.alu_op)
            pipe_pkg::ALU_ADD: alu_out = opr0_i + opb;
            pipe_pkg::ALU_SUB: alu_out = opr0_i - opb;
            pipe_pkg::ALU_AND: alu_out = opr0_i & opb;
            pipe_pkg::ALU_OR:  alu_out = opr0_i | opb;
            pipe_pkg::ALU_XOR: alu_out = opr0_i ^ opb;
            pipe_pkg::ALU_SHL: alu_out = opr0_i << opb[3:0];
            default:           alu_out = opb;
        endcase
    end

    assign go   = v_i && !stall_i;
    // a load completes in its second cycle
    assign done = go && (!d_info_i.load || ld_phase);

    assign stall_o = stall_i || (v_i && d_info_i.load && !ld_phase);

    // effective address is rs0 + imm through the adder
    assign dm.addr  = alu_out[DMEM_AW-1:0];
    assign dm.we    = go && d_info_i.store;
    assign dm.wdata = opr1_i;

    assign wb_data = d_info_i.load ? dm.rdata : alu_out;

    assign branch_o = go && (d_info_i.jmp || (d_info_i.beq && (opr0_i == opr1_i)));
    assign branch_addr_o = d_info_i.jmp ? imm_i[PC_W-1:0] : pc_i + imm_i[PC_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ld_phase <= 1'b0;
            v_o      <= 1'b0;
            wb_o     <= 1'b0;
        end else begin
            if (!stall_i) begin
                ld_phase <= v_i && d_info_i.load && !ld_phase;
            end
            v_o  <= done;
            wb_o <= done && d_info_i.wb_en;
        end
    end

    // write-back register
    always_ff @(posedge clk) begin
        if (done && d_info_i.wb_en) begin
            wb_r_o   <= wb_r_i;
            result_o <= wb_data;
        end
    end

    a_no_branch_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(branch_o && stall_i))
        else $error("branch raised during external stall");

    // decode must squash whatever followed the branch
    a_branch_squash: assert property (@(posedge clk) disable iff (!rst_n_i)
        branch_o |=> !v_i)
        else $error("instruction after taken branch reached execute");

endmodule

`default_nettype wire

//--- verilog/reg_file_sb.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file_sb (
    input  logic                           clk,
    input  logic                           rst_n_i,
    regfile_if.regs                        rf,
    input  logic                           wb_i,
    input  logic [cpu_isa_pkg::REG_AW-1:0] wb_r_i,
    input  logic [cpu_isa_pkg::DATA_W-1:0] result_i
);

    localparam int NREG = 1 << cpu_isa_pkg::REG_AW;

    logic [cpu_isa_pkg::DATA_W-1:0] gpr [NREG];
    logic [NREG-1:0]                rsv;
    logic [NREG-1:0]                set_mask;
    logic [NREG-1:0]                clr_mask;

    // combinational reads with no write bypass
    assign rf.opr0 = gpr[rf.r0];
    assign rf.opr1 = gpr[rf.r1];

    // both sources plus the destination must be free
    assign rf.reserved = rsv[rf.r0] | rsv[rf.r1] | rsv[rf.reserve_r];

    assign set_mask = rf.reserve ? (NREG'(1) << rf.reserve_r) : '0;
    assign clr_mask = wb_i ? (NREG'(1) << wb_r_i) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rsv <= '0;
        end else begin
            rsv <= (rsv & ~clr_mask) | set_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_i) begin
            gpr[wb_r_i] <= result_i;
        end
    end

    // every retiring write was reserved at issue
    a_wb_reserved: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_i |-> rsv[wb_r_i])
        else $error("write-back to unreserved r%0d", wb_r_i);

endmodule

`default_nettype wire

//--- verilog/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit #(
    parameter int PC_W = 8
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           v_i,
    input  logic [cpu_isa_pkg::INST_W-1:0] inst_i,
    input  logic [PC_W-1:0]                pc_i,
    input  logic                           stall_i,
    input  logic                           branch_i,
    output logic                           stall_o,
    regfile_if.decode                      rf,
    output logic                           v_o,
    output logic [PC_W-1:0]                pc_o,
    output logic [cpu_isa_pkg::DATA_W-1:0] opr0_o,
    output logic [cpu_isa_pkg::DATA_W-1:0] opr1_o,
    output logic [cpu_isa_pkg::DATA_W-1:0] imm_o,
    output logic [cpu_isa_pkg::REG_AW-1:0] wb_r_o,
    output pipe_pkg::d_info_t              d_info_o
);

    localparam int DW = cpu_isa_pkg::DATA_W;

    cpu_isa_pkg::opcode_e           opc;
    logic [cpu_isa_pkg::REG_AW-1:0] rd;
    logic [cpu_isa_pkg::REG_AW-1:0] rs0;
    logic [cpu_isa_pkg::REG_AW-1:0] rs1;
    logic [DW-1:0]                  imm_ext;
    logic                           alu_rr;
    logic                           uses_rs0;
    logic                           accept;
    pipe_pkg::d_info_t              info;

    assign opc = cpu_isa_pkg::opcode_e'(inst_i[cpu_isa_pkg::OPC_MSB:cpu_isa_pkg::OPC_LSB]);
    assign rd  = inst_i[cpu_isa_pkg::RD_MSB:cpu_isa_pkg::RD_LSB];
    assign rs0 = inst_i[cpu_isa_pkg::RS0_MSB:cpu_isa_pkg::RS0_LSB];
    assign rs1 = inst_i[cpu_isa_pkg::RS1_MSB:cpu_isa_pkg::RS1_LSB];

    always_comb begin
        info = '0;
        case (opc)
            cpu_isa_pkg::OP_SUB: info.alu_op = pipe_pkg::ALU_SUB;
            cpu_isa_pkg::OP_AND: info.alu_op = pipe_pkg::ALU_AND;
            cpu_isa_pkg::OP_OR:  info.alu_op = pipe_pkg::ALU_OR;
            cpu_isa_pkg::OP_XOR: info.alu_op = pipe_pkg::ALU_XOR;
            cpu_isa_pkg::OP_SHL: info.alu_op = pipe_pkg::ALU_SHL;
            cpu_isa_pkg::OP_LDI: info.alu_op = pipe_pkg::ALU_PASS_B;
            default:             info.alu_op = pipe_pkg::ALU_ADD;
        endcase
        alu_rr = opc inside {cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SUB, cpu_isa_pkg::OP_AND,
                             cpu_isa_pkg::OP_OR, cpu_isa_pkg::OP_XOR, cpu_isa_pkg::OP_SHL};
        uses_rs0 = alu_rr || (opc inside {cpu_isa_pkg::OP_ADDI, cpu_isa_pkg::OP_LD,
                                          cpu_isa_pkg::OP_ST, cpu_isa_pkg::OP_BEQ});
        info.use_imm = opc inside {cpu_isa_pkg::OP_LDI, cpu_isa_pkg::OP_ADDI,
                                   cpu_isa_pkg::OP_LD, cpu_isa_pkg::OP_ST};
        info.wb_en = alu_rr || (opc inside {cpu_isa_pkg::OP_LDI, cpu_isa_pkg::OP_ADDI,
                                            cpu_isa_pkg::OP_LD});
        info.load  = (opc == cpu_isa_pkg::OP_LD);
        info.store = (opc == cpu_isa_pkg::OP_ST);
        info.beq   = (opc == cpu_isa_pkg::OP_BEQ);
        info.jmp   = (opc == cpu_isa_pkg::OP_JMP);
        // imm8 for LDI, 12-bit target for JMP, signed imm4 otherwise
        if (opc == cpu_isa_pkg::OP_LDI) begin
            imm_ext = {{(DW-8){1'b0}}, inst_i[cpu_isa_pkg::RS0_MSB:cpu_isa_pkg::RS1_LSB]};
        end else if (opc == cpu_isa_pkg::OP_JMP) begin
            imm_ext = {{(DW-12){1'b0}}, inst_i[cpu_isa_pkg::RD_MSB:cpu_isa_pkg::RS1_LSB]};
        end else begin
            imm_ext = {{(DW-4){inst_i[cpu_isa_pkg::RS1_MSB]}}, rs1};
        end
    end

    // st and beq read rd on the second port; unused ports look at rd
    assign rf.r0        = uses_rs0 ? rs0 : rd;
    assign rf.r1        = alu_rr ? rs1 : rd;
    assign rf.reserve_r = rd;

    assign accept     = v_i && !rf.reserved && !stall_i && !branch_i;
    assign rf.reserve = accept && info.wb_en;
    assign stall_o    = stall_i || (v_i && rf.reserved);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            v_o <= 1'b0;
        end else if (branch_i) begin
            v_o <= 1'b0;
        end else if (!stall_i) begin
            v_o <= v_i && !rf.reserved;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_o     <= pc_i;
            opr0_o   <= rf.opr0;
            opr1_o   <= rf.opr1;
            imm_o    <= imm_ext;
            wb_r_o   <= rd;
            d_info_o <= info;
        end
    end

    a_reserve_free: assert property (@(posedge clk) disable iff (!rst_n_i)
        rf.reserve |-> !rf.reserved)
        else $error("reserve issued on a reserved register");

    a_known_opcode: assert property (@(posedge clk) disable iff (!rst_n_i)
        v_i |-> (opc <= cpu_isa_pkg::OP_JMP))
        else $error("undefined opcode %h in decode", opc);

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int PC_W = 8
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           stall_i,
    input  logic                           branch_i,
    input  logic [PC_W-1:0]                branch_addr_i,
    input  logic [cpu_isa_pkg::INST_W-1:0] inst_i,
    output logic [PC_W-1:0]                inst_addr_o,
    output logic                           v_o,
    output logic [cpu_isa_pkg::INST_W-1:0] inst_o,
    output logic [PC_W-1:0]                pc_o
);

    logic [PC_W-1:0] pc;

    // instruction memory answers in the same cycle
    assign inst_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc  <= '0;
            v_o <= 1'b0;
        end else if (branch_i) begin
            // redirect drops the wrong-path word now at inst_i
            pc  <= branch_addr_i;
            v_o <= 1'b0;
        end else if (!stall_i) begin
            pc  <= pc + 1'b1;
            v_o <= 1'b1;
        end
    end

    // fetch register payload
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            inst_o <= inst_i;
            pc_o   <= pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cpu_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// register read, reservation request and hazard flag
interface regfile_if;
    logic [cpu_isa_pkg::REG_AW-1:0] r0;
    logic [cpu_isa_pkg::REG_AW-1:0] r1;
    logic [cpu_isa_pkg::DATA_W-1:0] opr0;
    logic [cpu_isa_pkg::DATA_W-1:0] opr1;
    logic                           reserve;
    logic [cpu_isa_pkg::REG_AW-1:0] reserve_r;
    logic                           reserved;

    modport decode (
        output r0, r1, reserve, reserve_r,
        input  opr0, opr1, reserved
    );

    modport regs (
        input  r0, r1, reserve, reserve_r,
        output opr0, opr1, reserved
    );
endinterface

// single port data memory bus with rdata one cycle after addr
interface dmem_if #(
    parameter int DMEM_AW = 8
);
    logic [DMEM_AW-1:0]             addr;
    logic                           we;
    logic [cpu_isa_pkg::DATA_W-1:0] wdata;
    logic [cpu_isa_pkg::DATA_W-1:0] rdata;

    modport master (
        output addr, we, wdata,
        input  rdata
    );

    modport memory (
        input  addr, we, wdata,
        output rdata
    );
endinterface

`default_nettype wire

//--- verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // alu functions selected by decode
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_PASS_B
    } alu_op_e;

    // decoded control carried from decode into execute
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    wb_en;
        logic    load;
        logic    store;
        logic    beq;
        logic    jmp;
    } d_info_t;

endpackage

`default_nettype wire

//--- verilog/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    // datapath widths
    localparam int DATA_W = 16;
    localparam int INST_W = 16;
    localparam int REG_AW = 4;

    // opcode encodings
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_SHL  = 4'h6,
        OP_LDI  = 4'h7,
        OP_ADDI = 4'h8,
        OP_LD   = 4'h9,
        OP_ST   = 4'ha,
        OP_BEQ  = 4'hb,
        OP_JMP  = 4'hc
    } opcode_e;

    // instruction field positions
    localparam int OPC_MSB = 15;
    localparam int OPC_LSB = 12;
    localparam int RD_MSB  = 11;
    localparam int RD_LSB  = 8;
    localparam int RS0_MSB = 7;
    localparam int RS0_LSB = 4;
    // rs1 shares its bits with imm4
    localparam int RS1_MSB = 3;
    localparam int RS1_LSB = 0;

endpackage

`default_nettype wire
